// File: compile.f
+incdir+.
mips_pkg.sv
slot_if.sv
slot_check.sv
commit_merge.sv
commit_top.sv
commit_props.sv
tb_commit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_commit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module tb_commit;
    import mips_pkg::*;

    localparam int NUM_BUNDLES = 400;
    localparam int CYCLE_LIMIT = NUM_BUNDLES * 40 + 10;
    localparam logic [31:0] SEED = 32'hdd5f_5e3e;

    typedef struct packed {
        logic       done;
        logic       mem_en;
        logic       mem_write;
        word_t      mem_addr;
        word_t      wdata;
        strb_t      strb;
        logic [1:0] reg_write;
        reg_addr_t  dest1;
        reg_addr_t  dest0;
        word_t      result1;
        word_t      result0;
        logic       exc_valid;
        cause_t     cause;
        logic       addr_err;
        word_t      bad_addr;
        logic       redirect_valid;
        word_t      redirect_pc;
    } expect_t;

    logic       clk;
    logic       arst_n;
    exec_data_t in1;
    exec_data_t in0;
    logic       first_cycle;
    logic [5:0] ext_int;
    logic       timer_int;
    logic       dmem_en;
    logic       dmem_write;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    strb_t      dmem_strb;
    word_t      dmem_rdata;
    logic       dmem_ok;
    logic       done;
    logic       wb_valid;
    logic [1:0] wb_reg_write;
    reg_addr_t  wb_dest1;
    reg_addr_t  wb_dest0;
    word_t      wb_result1;
    word_t      wb_result0;
    logic       exc_valid;
    cause_t     exc_cause;
    word_t      exc_bad_addr;
    logic       redirect_valid;
    word_t      redirect_pc;

    int bundle_no = 0;
    int cycles = 0;

    commit_top i_commit_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopping after the first failure");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cause(input string name, input cause_t exp, input cause_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_strb(input string name, input strb_t exp, input strb_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic string name_of(input int tag, input string what);
        return $sformatf("bundle %0d %s", tag, what);
    endfunction

    function automatic logic is_load(input op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store(input op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // {fault, cause} for one slot by the exception priority
    function automatic logic [5:0] find_fault(input exec_data_t d, input logic intr);
        logic mis;
        mis = ((d.op inside {OP_LH, OP_LHU, OP_SH}) && d.result[0])
            || ((d.op inside {OP_LW, OP_SW}) && d.result[1:0] != 2'b00);
        if (intr)
            return {1'b1, `CAUSE_INT};
        else if (d.op == OP_RESERVED)
            return {1'b1, `CAUSE_RI};
        else if (d.op == OP_SYSCALL)
            return {1'b1, `CAUSE_SYS};
        else if (d.op == OP_BREAK)
            return {1'b1, `CAUSE_BP};
        else if (d.op == OP_ALU && d.overflow)
            return {1'b1, `CAUSE_OV};
        else if (mis && is_load(d.op))
            return {1'b1, `CAUSE_ADEL};
        else if (mis && is_store(d.op))
            return {1'b1, `CAUSE_ADES};
        return 6'b0;
    endfunction

    function automatic expect_t ref_commit(input exec_data_t i1, input exec_data_t i0,
                                           input logic [5:0] ei, input logic ti,
                                           input logic fc, input logic ok, input word_t rdata);
        expect_t    e;
        logic [5:0] f1;
        logic [5:0] f0;
        logic       e1;
        logic       e0;
        logic       ok1;
        logic       ok0;
        logic       live0;
        logic       eret1;
        logic       eret0;
        logic       mem1;
        logic       mem0;
        exec_data_t m;
        logic [1:0] a;
        logic [7:0] byte_v;
        logic [15:0] half_v;
        word_t      ld;
        e     = '0;
        f1    = find_fault(i1, (|ei) | ti);
        f0    = find_fault(i0, 1'b0);
        e1    = i1.valid & f1[5];
        ok1   = i1.valid & ~f1[5];
        eret1 = ok1 && i1.op == OP_ERET;
        // an older fault or eret squashes the younger slot
        live0 = i0.valid & ~e1 & ~eret1;
        e0    = live0 & f0[5];
        ok0   = live0 & ~f0[5];
        eret0 = ok0 && i0.op == OP_ERET;
        mem1  = ok1 && (is_load(i1.op) || is_store(i1.op));
        mem0  = ok0 && (is_load(i0.op) || is_store(i0.op));
        m     = mem1 ? i1 : i0;
        a     = m.result[1:0];
        e.mem_en    = mem1 | mem0;
        e.mem_write = e.mem_en & is_store(m.op);
        e.mem_addr  = m.result;
        e.done      = fc ? ~e.mem_en : (~e.mem_en | ok);
        case (m.op)
            OP_SB: begin
                e.strb  = 4'b0001 << a;
                e.wdata = m.store_data << (8 * a);
            end
            OP_SH: begin
                e.strb  = 4'b0011 << a;
                e.wdata = m.store_data << (8 * a);
            end
            default: begin
                e.strb  = 4'b1111;
                e.wdata = m.store_data;
            end
        endcase
        byte_v = rdata[8 * a +: 8];
        half_v = rdata[16 * a[1] +: 16];
        case (m.op)
            OP_LB:   ld = {{24{byte_v[7]}}, byte_v};
            OP_LBU:  ld = {24'b0, byte_v};
            OP_LH:   ld = {{16{half_v[15]}}, half_v};
            OP_LHU:  ld = {16'b0, half_v};
            default: ld = rdata;
        endcase
        e.reg_write = {ok1 & i1.reg_write, ok0 & i0.reg_write};
        e.dest1     = i1.dest;
        e.dest0     = i0.dest;
        e.result1   = (mem1 && is_load(i1.op)) ? ld : i1.result;
        e.result0   = (mem0 && is_load(i0.op)) ? ld : i0.result;
        e.exc_valid = e1 | e0;
        e.cause     = e1 ? f1[4:0] : f0[4:0];
        e.bad_addr  = e1 ? i1.result : i0.result;
        e.addr_err  = e.cause == `CAUSE_ADEL || e.cause == `CAUSE_ADES;
        e.redirect_valid = 1'b1;
        if (e.exc_valid)
            e.redirect_pc = `EXC_VECTOR;
        else if (eret1)
            e.redirect_pc = i1.epc;
        else if (eret0)
            e.redirect_pc = i0.epc;
        else if (ok1 && ((i1.op == OP_BRANCH && i1.taken) || i1.op == OP_JUMP
                 || i1.op == OP_JR))
            e.redirect_pc = i1.target;
        else
            e.redirect_valid = 1'b0;
        return e;
    endfunction

    function automatic exec_data_t rand_slot();
        exec_data_t d;
        d.valid      = ($urandom % 8) != 0;
        d.op         = op_t'(4'($urandom));
        d.pc         = $urandom;
        d.result     = $urandom;
        d.store_data = $urandom;
        d.dest       = 5'($urandom);
        d.reg_write  = 1'($urandom);
        d.overflow   = ($urandom % 8) == 0;
        d.taken      = 1'($urandom);
        d.target     = $urandom;
        d.epc        = $urandom;
        // most accesses are aligned so that they reach memory
        if (($urandom % 4) != 0) begin
            if (d.op inside {OP_LH, OP_LHU, OP_SH}) begin
                d.result[0] = 1'b0;
            end
            if (d.op inside {OP_LW, OP_SW}) begin
                d.result[1:0] = 2'b00;
            end
        end
        return d;
    endfunction

    task automatic drive_bundle();
        in1 = rand_slot();
        in0 = rand_slot();
        // issue never pairs two memory ops
        if ((is_load(in1.op) || is_store(in1.op)) && (is_load(in0.op) || is_store(in0.op))) begin
            in0.op = OP_ALU;
        end
        ext_int     = (($urandom % 16) == 0) ? 6'($urandom) : 6'd0;
        timer_int   = ($urandom % 16) == 0;
        first_cycle = 1'b1;
        dmem_ok     = 1'($urandom);
        dmem_rdata  = $urandom;
    endtask

    initial begin : stimulus
        int delay;
        int waited;
        in1         = '0;
        in0         = '0;
        first_cycle = 1'b1;
        ext_int     = 6'd0;
        timer_int   = 1'b0;
        dmem_rdata  = '0;
        dmem_ok     = 1'b0;
        arst_n      = 1'b0;
        void'($urandom(SEED));
        repeat (3) @(negedge clk);
        check_bit("reset wb_valid", 1'b0, wb_valid);
        check_bit("reset wb_reg_write", 1'b0, |wb_reg_write);
        check_bit("reset exc_valid", 1'b0, exc_valid);
        check_bit("reset redirect_valid", 1'b0, redirect_valid);
        arst_n = 1'b1;
        for (int n = 0; n < NUM_BUNDLES; n++) begin
            bundle_no = n;
            drive_bundle();
            delay  = int'($urandom_range(3, 0));
            waited = 0;
            @(posedge clk);
            while (!done) begin
                // memory model answers after the drawn delay
                @(negedge clk);
                first_cycle = 1'b0;
                dmem_ok     = waited >= delay;
                waited++;
                @(posedge clk);
            end
            @(negedge clk);
        end
        @(negedge clk);
        #5;
        if (i_commit_top.u_merge.u_props.fail_count != 0) begin
            stop_run("a bound assertion on the commit outputs failed");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    initial begin : compare
        expect_t e;
        logic    took;
        int      tag;
        word_t   mask;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            tag  = bundle_no;
            e    = ref_commit(in1, in0, ext_int, timer_int, first_cycle, dmem_ok, dmem_rdata);
            took = e.done;
            check_bit(name_of(tag, "done"), e.done, done);
            check_bit(name_of(tag, "dmem_en"), e.mem_en, dmem_en);
            check_bit(name_of(tag, "dmem_write"), e.mem_write, dmem_write);
            if (e.mem_en) begin
                check_word(name_of(tag, "dmem_addr"), e.mem_addr, dmem_addr);
            end
            if (e.mem_write) begin
                check_strb(name_of(tag, "dmem_strb"), e.strb, dmem_strb);
                mask = {{8{e.strb[3]}}, {8{e.strb[2]}}, {8{e.strb[1]}}, {8{e.strb[0]}}};
                check_word(name_of(tag, "dmem_wdata"), e.wdata & mask, dmem_wdata & mask);
            end
            // registered results show up one cycle after done
            @(negedge clk);
            check_bit(name_of(tag, "wb_valid"), took, wb_valid);
            check_bit(name_of(tag, "wb_reg_write[1]"), took & e.reg_write[1], wb_reg_write[1]);
            check_bit(name_of(tag, "wb_reg_write[0]"), took & e.reg_write[0], wb_reg_write[0]);
            check_bit(name_of(tag, "exc_valid"), took & e.exc_valid, exc_valid);
            check_bit(name_of(tag, "redirect_valid"), took & e.redirect_valid, redirect_valid);
            if (took && e.reg_write[1]) begin
                check_reg(name_of(tag, "wb_dest1"), e.dest1, wb_dest1);
                check_word(name_of(tag, "wb_result1"), e.result1, wb_result1);
            end
            if (took && e.reg_write[0]) begin
                check_reg(name_of(tag, "wb_dest0"), e.dest0, wb_dest0);
                check_word(name_of(tag, "wb_result0"), e.result0, wb_result0);
            end
            if (took && e.exc_valid) begin
                check_cause(name_of(tag, "exc_cause"), e.cause, exc_cause);
                if (e.addr_err) begin
                    check_word(name_of(tag, "exc_bad_addr"), e.bad_addr, exc_bad_addr);
                end
            end
            if (took && e.redirect_valid) begin
                check_word(name_of(tag, "redirect_pc"), e.redirect_pc, redirect_pc);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run("timeout: the bundles did not complete within the cycle limit");
        end else if (i_commit_top.u_merge.u_props.fail_count != 0) begin
            stop_run("a bound assertion on the commit outputs failed");
        end
    end

endmodule

`default_nettype wire

// File: commit_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module commit_props (
    input logic            clk,
    input logic            arst_n,
    input logic            dmem_en,
    input logic            dmem_write,
    input mips_pkg::strb_t dmem_strb,
    input logic            done,
    input logic            wb_valid,
    input logic [1:0]      wb_reg_write,
    input logic            exc_valid,
    input logic            redirect_valid,
    input mips_pkg::word_t redirect_pc
);

    int fail_count = 0;

    a_strb_write: assert property (@(posedge clk) disable iff (!arst_n)
        (dmem_strb != '0) |-> (dmem_en && dmem_write))
        else begin
            $error("byte strobes active without a memory write");
            fail_count++;
        end

    // a waiting access keeps its request on the port
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (dmem_en && !done) |=> (dmem_en && $stable(dmem_write) && $stable(dmem_strb)))
        else begin
            $error("memory request changed while the access was pending");
            fail_count++;
        end

    a_wb_follow: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> wb_valid)
        else begin
            $error("wb_valid missing one cycle after done");
            fail_count++;
        end

    a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !done |=> (!wb_valid && wb_reg_write == 2'b00))
        else begin
            $error("writeback raised without done");
            fail_count++;
        end

    a_exc_vector: assert property (@(posedge clk) disable iff (!arst_n)
        exc_valid |-> (redirect_valid && redirect_pc == `EXC_VECTOR))
        else begin
            $error("exception without a redirect to the vector");
            fail_count++;
        end

endmodule

bind commit_merge commit_props u_props (
    .clk            (clk),
    .arst_n         (arst_n),
    .dmem_en        (dmem_en),
    .dmem_write     (dmem_write),
    .dmem_strb      (dmem_strb),
    .done           (done),
    .wb_valid       (wb_valid),
    .wb_reg_write   (wb_reg_write),
    .exc_valid      (exc_valid),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
);

`default_nettype wire

// File: commit_top.sv
`timescale 1ns/1ps
`default_nettype none

module commit_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mips_pkg::exec_data_t in1,
    input  mips_pkg::exec_data_t in0,
    input  logic                 first_cycle,
    input  logic [5:0]           ext_int,
    input  logic                 timer_int,
    output logic                 dmem_en,
    output logic                 dmem_write,
    output mips_pkg::word_t      dmem_addr,
    output mips_pkg::word_t      dmem_wdata,
    output mips_pkg::strb_t      dmem_strb,
    input  mips_pkg::word_t      dmem_rdata,
    input  logic                 dmem_ok,
    output logic                 done,
    output logic                 wb_valid,
    output logic [1:0]           wb_reg_write,
    output mips_pkg::reg_addr_t  wb_dest1,
    output mips_pkg::reg_addr_t  wb_dest0,
    output mips_pkg::word_t      wb_result1,
    output mips_pkg::word_t      wb_result0,
    output logic                 exc_valid,
    output mips_pkg::cause_t     exc_cause,
    output mips_pkg::word_t      exc_bad_addr,
    output logic                 redirect_valid,
    output mips_pkg::word_t      redirect_pc
);

    logic kill0;
    logic int_pending;

    slot_if s1_if ();
    slot_if s0_if ();

    // slot 1 is never killed and alone sees interrupts
    slot_check u_slot1 (
        .in          (in1),
        .kill        (1'b0),
        .int_pending (int_pending),
        .res         (s1_if.check)
    );

    slot_check u_slot0 (
        .in          (in0),
        .kill        (kill0),
        .int_pending (1'b0),
        .res         (s0_if.check)
    );

    commit_merge u_merge (
        .clk            (clk),
        .arst_n         (arst_n),
        .s1             (s1_if.merge),
        .s0             (s0_if.merge),
        .ext_int        (ext_int),
        .timer_int      (timer_int),
        .first_cycle    (first_cycle),
        .dmem_en        (dmem_en),
        .dmem_write     (dmem_write),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_strb      (dmem_strb),
        .dmem_rdata     (dmem_rdata),
        .dmem_ok        (dmem_ok),
        .done           (done),
        .kill0          (kill0),
        .int_pending    (int_pending),
        .wb_valid       (wb_valid),
        .wb_reg_write   (wb_reg_write),
        .wb_dest1       (wb_dest1),
        .wb_dest0       (wb_dest0),
        .wb_result1     (wb_result1),
        .wb_result0     (wb_result0),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_bad_addr   (exc_bad_addr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// File: commit_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module commit_merge (
    input  logic                clk,
    input  logic                arst_n,
    slot_if.merge               s1,
    slot_if.merge               s0,
    input  logic [5:0]          ext_int,
    input  logic                timer_int,
    input  logic                first_cycle,
    output logic                dmem_en,
    output logic                dmem_write,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_wdata,
    output mips_pkg::strb_t     dmem_strb,
    input  mips_pkg::word_t     dmem_rdata,
    input  logic                dmem_ok,
    output logic                done,
    output logic                kill0,
    output logic                int_pending,
    output logic                wb_valid,
    output logic [1:0]          wb_reg_write,
    output mips_pkg::reg_addr_t wb_dest1,
    output mips_pkg::reg_addr_t wb_dest0,
    output mips_pkg::word_t     wb_result1,
    output mips_pkg::word_t     wb_result0,
    output logic                exc_valid,
    output mips_pkg::cause_t    exc_cause,
    output mips_pkg::word_t     exc_bad_addr,
    output logic                redirect_valid,
    output mips_pkg::word_t     redirect_pc
);
    import mips_pkg::*;

    logic  use1;
    op_t   m_op;
    word_t m_sdata;
    word_t lane;
    word_t load_data;
    word_t res1;
    word_t res0;
    logic  exc_any;
    logic  redir_req;
    word_t redir_pc;

    assign int_pending = (|ext_int) | timer_int;
    assign kill0       = s1.exc_valid | s1.is_eret;

    // older slot owns the port when it has an access
    assign use1       = s1.mem_en;
    assign dmem_en    = s1.mem_en | s0.mem_en;
    assign dmem_write = use1 ? s1.mem_write : s0.mem_write;
    assign dmem_addr  = use1 ? s1.mem_addr : s0.mem_addr;
    assign m_op       = use1 ? s1.mem_op : s0.mem_op;
    assign m_sdata    = use1 ? s1.store_data : s0.store_data;

    always_comb begin
        dmem_strb  = '0;
        dmem_wdata = m_sdata;
        case (m_op)
            OP_SB: begin
                dmem_strb  = 4'b0001 << dmem_addr[1:0];
                dmem_wdata = {24'b0, m_sdata[7:0]} << {dmem_addr[1:0], 3'b000};
            end
            OP_SH: begin
                dmem_strb  = 4'b0011 << {dmem_addr[1], 1'b0};
                dmem_wdata = {16'b0, m_sdata[15:0]} << {dmem_addr[1], 4'b0000};
            end
            OP_SW: begin
                dmem_strb = 4'b1111;
            end
            default: begin
                dmem_strb = '0;
            end
        endcase
        if (!dmem_write) begin
            dmem_strb = '0;
        end
    end

    // bring the addressed byte or halfword down to bit 0
    assign lane = dmem_rdata >> {dmem_addr[1:0], 3'b000};

    always_comb begin
        case (m_op)
            OP_LB:   load_data = {{24{lane[7]}}, lane[7:0]};
            OP_LBU:  load_data = {24'b0, lane[7:0]};
            OP_LH:   load_data = {{16{lane[15]}}, lane[15:0]};
            OP_LHU:  load_data = {16'b0, lane[15:0]};
            default: load_data = dmem_rdata;
        endcase
    end

    assign res1 = (s1.mem_en & ~s1.mem_write) ? load_data : s1.result;
    assign res0 = (~use1 & s0.mem_en & ~s0.mem_write) ? load_data : s0.result;

    assign done = first_cycle ? ~dmem_en : (~dmem_en | dmem_ok);

    assign exc_any = s1.exc_valid | s0.exc_valid;

    // exception, then eret, then slot 1 control flow
    assign redir_req = exc_any | s0.is_eret | s1.redirect_req;
    assign redir_pc  = exc_any    ? `EXC_VECTOR :
                       s0.is_eret ? s0.redirect_pc : s1.redirect_pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid       <= 1'b0;
            wb_reg_write   <= 2'b00;
            exc_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= done;
            wb_reg_write   <= done ? {s1.reg_write, s0.reg_write} : 2'b00;
            exc_valid      <= done & exc_any;
            redirect_valid <= done & redir_req;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            wb_dest1     <= s1.dest;
            wb_dest0     <= s0.dest;
            wb_result1   <= res1;
            wb_result0   <= res0;
            exc_cause    <= s1.exc_valid ? s1.exc_cause : s0.exc_cause;
            exc_bad_addr <= s1.exc_valid ? s1.bad_addr : s0.bad_addr;
            redirect_pc  <= redir_pc;
        end
    end

endmodule

`default_nettype wire

// File: slot_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module slot_check (
    input  mips_pkg::exec_data_t in,
    input  logic                 kill,
    input  logic                 int_pending,
    slot_if.check                res
);
    import mips_pkg::*;

    logic   live;
    logic   is_load;
    logic   is_store;
    logic   is_half;
    logic   is_word;
    logic   misaligned;
    logic   fault;
    logic   ok;
    logic   is_eret;
    cause_t cause;

    assign live     = in.valid & ~kill;
    assign is_load  = in.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign is_store = in.op inside {OP_SB, OP_SH, OP_SW};
    assign is_half  = in.op inside {OP_LH, OP_LHU, OP_SH};
    assign is_word  = in.op inside {OP_LW, OP_SW};

    assign misaligned = (is_half & in.result[0]) | (is_word & (|in.result[1:0]));

    // highest priority first
    always_comb begin
        fault = 1'b1;
        cause = `CAUSE_INT;
        if (int_pending) begin
            cause = `CAUSE_INT;
        end else if (in.op == OP_RESERVED) begin
            cause = `CAUSE_RI;
        end else if (in.op == OP_SYSCALL) begin
            cause = `CAUSE_SYS;
        end else if (in.op == OP_BREAK) begin
            cause = `CAUSE_BP;
        end else if (in.op == OP_ALU && in.overflow) begin
            cause = `CAUSE_OV;
        end else if (misaligned && is_load) begin
            cause = `CAUSE_ADEL;
        end else if (misaligned && is_store) begin
            cause = `CAUSE_ADES;
        end else begin
            fault = 1'b0;
        end
    end

    assign res.exc_valid = live & fault;
    assign res.exc_cause = cause;
    // badvaddr only carries meaning for address errors
    assign res.bad_addr  = (cause == `CAUSE_ADEL || cause == `CAUSE_ADES) ? in.result : '0;

    // a faulting instruction leaves no side effects
    assign ok = live & ~fault;

    assign res.mem_en     = ok & (is_load | is_store);
    assign res.mem_write  = ok & is_store;
    assign res.mem_op     = in.op;
    assign res.mem_addr   = in.result;
    assign res.store_data = in.store_data;

    assign res.reg_write = ok & in.reg_write;
    assign res.dest      = in.dest;
    assign res.result    = in.result;

    assign is_eret     = ok & (in.op == OP_ERET);
    assign res.is_eret = is_eret;

    assign res.redirect_req = is_eret
                            | (ok & (((in.op == OP_BRANCH) & in.taken)
                            | (in.op == OP_JUMP) | (in.op == OP_JR)));
    assign res.redirect_pc  = is_eret ? in.epc : in.target;

endmodule

`default_nettype wire

// File: slot_if.sv
`timescale 1ns/1ps
`default_nettype none

interface slot_if;
    import mips_pkg::*;

    logic      exc_valid;
    cause_t    exc_cause;
    word_t     bad_addr;
    logic      mem_en;
    logic      mem_write;
    op_t       mem_op;
    word_t     mem_addr;
    word_t     store_data;
    logic      reg_write;
    reg_addr_t dest;
    word_t     result;
    logic      is_eret;
    logic      redirect_req;
    word_t     redirect_pc;

    // checker side drives, merge side reads
    modport check (
        output exc_valid, exc_cause, bad_addr,
        output mem_en, mem_write, mem_op, mem_addr, store_data,
        output reg_write, dest, result,
        output is_eret, redirect_req, redirect_pc
    );

    modport merge (
        input exc_valid, exc_cause, bad_addr,
        input mem_en, mem_write, mem_op, mem_addr, store_data,
        input reg_write, dest, result,
        input is_eret, redirect_req, redirect_pc
    );

endinterface

`default_nettype wire

// File: mips_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    typedef logic [`DATA_W-1:0]   word_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [4:0]           cause_t;
    typedef logic [`DATA_W/8-1:0] strb_t;

    // operation class after decode
    typedef enum logic [3:0] {
        OP_ALU,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BRANCH,
        OP_JUMP,
        OP_JR,
        OP_ERET,
        OP_SYSCALL,
        OP_BREAK,
        OP_RESERVED
    } op_t;

    // one executed instruction entering commit
    typedef struct packed {
        logic      valid;
        op_t       op;
        word_t     pc;
        // alu result, or the address for loads and stores
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_write;
        logic      overflow;
        logic      taken;
        word_t     target;
        word_t     epc;
    } exec_data_t;

endpackage

`default_nettype wire

// File: mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath and address width
`define DATA_W 32

// general exception entry
`define EXC_VECTOR 32'hbfc00380

// cp0 cause codes
`define CAUSE_INT  5'h00
`define CAUSE_ADEL 5'h04
`define CAUSE_ADES 5'h05
`define CAUSE_SYS  5'h08
`define CAUSE_BP   5'h09
`define CAUSE_RI   5'h0a
`define CAUSE_OV   5'h0c

`endif
